/* include/issue_defs.svh */
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Station geometry
`define RS_QUEUE_SIZE 8
`define RS_NUM_LANES 2
`define RS_RESULT_BUSES 2

// Physical register tag and sequence number
`define RS_TAG_W 6
`define RS_SQN_W 6

// Must hold RS_QUEUE_SIZE itself
`define RS_FREE_W 4

`endif

/* verilog/CorePkg.sv */
`default_nettype none

package CorePkg;

    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_MUL
    } FuType;

    // Opcode space shared by all functional units
    typedef enum logic [4:0] {
        // Integer ALU
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_AUIPC,
        // Branches and jumps
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        // Loads
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        // Stores
        OP_SB,
        OP_SH,
        OP_SW,
        // Multiplier
        OP_MUL,
        OP_MULH
    } OpCode;

endpackage

`default_nettype wire

/* verilog/IssuePkg.sv */
`default_nettype none

`include "issue_defs.svh"

package IssuePkg;

    typedef enum logic [1:0] {
        IC_SIMPLE,
        IC_LOAD,
        IC_STORE,
        IC_BRANCH
    } IssueClass;

    // One station slot, sources are woken up in place
    typedef struct packed {
        CorePkg::FuType fu;
        CorePkg::OpCode opcode;
        logic [`RS_TAG_W-1:0] tagA;
        logic availA;
        logic [`RS_TAG_W-1:0] tagB;
        logic availB;
        logic [`RS_TAG_W-1:0] tagDst;
        logic [`RS_SQN_W-1:0] sqN;
        IssueClass issueClass;
    } RsEntry;

    // True when a comes after b in program order
    function automatic logic sqnYounger(input logic [`RS_SQN_W-1:0] a,
                                        input logic [`RS_SQN_W-1:0] b);
        logic [`RS_SQN_W-1:0] diff;
        diff = a - b;
        return !diff[`RS_SQN_W-1] && (diff != '0);
    endfunction

endpackage

`default_nettype wire

/* verilog/StoreOrderQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module StoreOrderQueue (
    input wire clk,
    input wire rst,

    input wire push[`RS_NUM_LANES-1:0],
    input wire [`RS_SQN_W-1:0] pushSqN[`RS_NUM_LANES-1:0],
    input wire pop,

    input wire invalidate,
    input wire [`RS_SQN_W-1:0] invalidateSqN,

    output logic [`RS_SQN_W-1:0] headSqN,
    output logic empty
);

// Each store in flight still owns a station entry, so this depth cannot overflow
localparam int DEPTH = `RS_QUEUE_SIZE;
localparam int IDX_W = $clog2(DEPTH);
localparam int PTR_W = IDX_W + 1;
localparam int LANES = `RS_NUM_LANES;

logic [`RS_SQN_W-1:0] slots[DEPTH];
logic [PTR_W-1:0] inPtr;
logic [PTR_W-1:0] outPtr;
logic [PTR_W-1:0] pushCount;
logic [IDX_W-1:0] writeIdx[LANES];
logic rolling;
logic [`RS_SQN_W-1:0] rollSqN;
logic [`RS_SQN_W-1:0] tailSqN;

assign empty = (inPtr == outPtr);
assign headSqN = slots[outPtr[IDX_W-1:0]];
assign tailSqN = slots[IDX_W'(inPtr - 1'b1)];

// Lane 0 is older, so it takes the first free slot
always_comb begin
    pushCount = '0;
    for (int l = 0; l < LANES; l++) begin
        writeIdx[l] = IDX_W'(inPtr + pushCount);
        pushCount = pushCount + PTR_W'(push[l]);
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        inPtr <= '0;
        outPtr <= '0;
        rolling <= 1'b0;
    end else begin
        if (pop)
            outPtr <= outPtr + 1'b1;

        if (invalidate) begin
            rolling <= 1'b1;
            rollSqN <= invalidateSqN;
        end else if (rolling) begin
            // Drop one younger store per cycle from the tail
            if (!empty && IssuePkg::sqnYounger(tailSqN, rollSqN))
                inPtr <= inPtr - 1'b1;
            else
                rolling <= 1'b0;
        end else begin
            inPtr <= inPtr + pushCount;
        end
    end
end

// Dispatch restarts after a redirect, by then the walk is over
always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
        if (push[l] && !rolling && !invalidate)
            slots[writeIdx[l]] <= pushSqN[l];
    end
end

endmodule

`default_nettype wire

/* verilog/ReservationStation.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module ReservationStation (
    input wire clk,
    input wire rst,

    input wire uopValid[`RS_NUM_LANES-1:0],
    input wire CorePkg::FuType uopFu[`RS_NUM_LANES-1:0],
    input wire CorePkg::OpCode uopOpcode[`RS_NUM_LANES-1:0],
    input wire [`RS_TAG_W-1:0] uopTagA[`RS_NUM_LANES-1:0],
    input wire uopAvailA[`RS_NUM_LANES-1:0],
    input wire [`RS_TAG_W-1:0] uopTagB[`RS_NUM_LANES-1:0],
    input wire uopAvailB[`RS_NUM_LANES-1:0],
    input wire [`RS_TAG_W-1:0] uopTagDst[`RS_NUM_LANES-1:0],
    input wire [`RS_SQN_W-1:0] uopSqN[`RS_NUM_LANES-1:0],
    input wire wbStall[`RS_NUM_LANES-1:0],

    input wire resultValid[`RS_RESULT_BUSES-1:0],
    input wire [`RS_TAG_W-1:0] resultTag[`RS_RESULT_BUSES-1:0],

    input wire invalidate,
    input wire [`RS_SQN_W-1:0] invalidateSqN,
    input wire maxCommitSqNValid,
    input wire [`RS_SQN_W-1:0] maxCommitSqN,
    input wire [`RS_SQN_W-1:0] sqHeadSqN,
    input wire sqEmpty,

    output logic issueValid[`RS_NUM_LANES-1:0],
    output CorePkg::FuType issueFu[`RS_NUM_LANES-1:0],
    output CorePkg::OpCode issueOpcode[`RS_NUM_LANES-1:0],
    output logic [`RS_TAG_W-1:0] issueTagDst[`RS_NUM_LANES-1:0],
    output logic [`RS_SQN_W-1:0] issueSqN[`RS_NUM_LANES-1:0],

    output logic sqPush[`RS_NUM_LANES-1:0],
    output logic [`RS_SQN_W-1:0] sqPushSqN[`RS_NUM_LANES-1:0],
    output logic sqPop,
    output logic [`RS_FREE_W-1:0] freeCount
);

localparam int QSIZE = `RS_QUEUE_SIZE;
localparam int LANES = `RS_NUM_LANES;
localparam int BUSES = `RS_RESULT_BUSES;
localparam int IDX_W = $clog2(QSIZE);
localparam int FREE_W = `RS_FREE_W;

IssuePkg::RsEntry entries[QSIZE];
logic [QSIZE-1:0] entryValid;
logic [QSIZE-1:0] validNext;
logic [QSIZE-1:0] claimed;
logic [QSIZE-1:0] eligible;

IssuePkg::RsEntry newEntry[LANES];
logic enqValid[LANES];
logic [IDX_W-1:0] enqIdx[LANES];

logic pickValid[LANES];
logic [IDX_W-1:0] pickIdx[LANES];
logic take[LANES];

function automatic IssuePkg::IssueClass classify(input CorePkg::FuType fu,
                                                 input CorePkg::OpCode op);
    IssuePkg::IssueClass cls;
    cls = IssuePkg::IC_SIMPLE;
    if (fu == CorePkg::FU_LSU) begin
        case (op)
            CorePkg::OP_LB, CorePkg::OP_LH, CorePkg::OP_LW,
            CorePkg::OP_LBU, CorePkg::OP_LHU:
                cls = IssuePkg::IC_LOAD;
            CorePkg::OP_SB, CorePkg::OP_SH, CorePkg::OP_SW:
                cls = IssuePkg::IC_STORE;
            default:
                cls = IssuePkg::IC_SIMPLE;
        endcase
    end else if (fu == CorePkg::FU_INT) begin
        case (op)
            CorePkg::OP_BEQ, CorePkg::OP_BNE, CorePkg::OP_BLT, CorePkg::OP_BGE,
            CorePkg::OP_BLTU, CorePkg::OP_BGEU, CorePkg::OP_JAL, CorePkg::OP_JALR:
                cls = IssuePkg::IC_BRANCH;
            default:
                cls = IssuePkg::IC_SIMPLE;
        endcase
    end
    return cls;
endfunction

always_comb begin
    for (int l = 0; l < LANES; l++) begin
        newEntry[l].fu = uopFu[l];
        newEntry[l].opcode = uopOpcode[l];
        newEntry[l].tagA = uopTagA[l];
        newEntry[l].availA = uopAvailA[l];
        newEntry[l].tagB = uopTagB[l];
        newEntry[l].availB = uopAvailB[l];
        newEntry[l].tagDst = uopTagDst[l];
        newEntry[l].sqN = uopSqN[l];
        newEntry[l].issueClass = classify(uopFu[l], uopOpcode[l]);
        // Catch a broadcast that lands in the dispatch cycle
        for (int b = 0; b < BUSES; b++) begin
            if (resultValid[b] && resultTag[b] == uopTagA[l])
                newEntry[l].availA = 1'b1;
            if (resultValid[b] && resultTag[b] == uopTagB[l])
                newEntry[l].availB = 1'b1;
        end
    end
end

// Readiness plus memory ordering, independent of lane
always_comb begin
    for (int j = 0; j < QSIZE; j++) begin
        eligible[j] = entryValid[j] && entries[j].availA && entries[j].availB && !invalidate;
        if (entries[j].issueClass == IssuePkg::IC_LOAD)
            eligible[j] = eligible[j]
                && (sqEmpty || IssuePkg::sqnYounger(sqHeadSqN, entries[j].sqN));
        if (entries[j].issueClass == IssuePkg::IC_STORE)
            eligible[j] = eligible[j] && !sqEmpty && sqHeadSqN == entries[j].sqN
                && !(maxCommitSqNValid && IssuePkg::sqnYounger(entries[j].sqN, maxCommitSqN));
    end
end

// Oldest eligible entry per lane, lane 1 only takes simple ops
always_comb begin
    for (int i = 0; i < LANES; i++) begin
        pickValid[i] = 1'b0;
        pickIdx[i] = '0;
        for (int j = 0; j < QSIZE; j++) begin
            if (eligible[j]
                    && (i == 0 || entries[j].issueClass == IssuePkg::IC_SIMPLE)
                    && !(i > 0 && take[0] && pickIdx[0] == IDX_W'(j))
                    && (!pickValid[i]
                        || IssuePkg::sqnYounger(entries[pickIdx[i]].sqN, entries[j].sqN))) begin
                pickValid[i] = 1'b1;
                pickIdx[i] = IDX_W'(j);
            end
        end
        take[i] = pickValid[i] && !wbStall[i];
    end
end

always_comb begin
    validNext = entryValid;
    claimed = '0;
    for (int l = 0; l < LANES; l++) begin
        enqValid[l] = 1'b0;
        enqIdx[l] = '0;
        for (int j = 0; j < QSIZE; j++) begin
            if (uopValid[l] && !invalidate && !enqValid[l] && !entryValid[j] && !claimed[j]) begin
                enqValid[l] = 1'b1;
                enqIdx[l] = IDX_W'(j);
                claimed[j] = 1'b1;
            end
        end
        if (take[l])
            validNext[pickIdx[l]] = 1'b0;
    end
    validNext = validNext | claimed;
    if (invalidate) begin
        for (int j = 0; j < QSIZE; j++) begin
            if (IssuePkg::sqnYounger(entries[j].sqN, invalidateSqN))
                validNext[j] = 1'b0;
        end
    end
end

// Only lane 0 ever issues a store
always_comb begin
    for (int l = 0; l < LANES; l++) begin
        sqPush[l] = enqValid[l] && newEntry[l].issueClass == IssuePkg::IC_STORE;
        sqPushSqN[l] = uopSqN[l];
    end
    sqPop = take[0] && entries[pickIdx[0]].issueClass == IssuePkg::IC_STORE;
end

always_ff @(posedge clk) begin
    if (rst) begin
        entryValid <= '0;
        freeCount <= FREE_W'(QSIZE);
        for (int i = 0; i < LANES; i++)
            issueValid[i] <= 1'b0;
    end else begin
        entryValid <= validNext;
        freeCount <= FREE_W'(QSIZE - $countones(validNext));
        for (int i = 0; i < LANES; i++) begin
            if (invalidate)
                issueValid[i] <= 1'b0;
            else if (!wbStall[i])
                issueValid[i] <= pickValid[i];
        end
    end
end

always_ff @(posedge clk) begin
    for (int j = 0; j < QSIZE; j++) begin
        for (int b = 0; b < BUSES; b++) begin
            if (resultValid[b] && entries[j].tagA == resultTag[b])
                entries[j].availA <= 1'b1;
            if (resultValid[b] && entries[j].tagB == resultTag[b])
                entries[j].availB <= 1'b1;
        end
    end
    for (int l = 0; l < LANES; l++) begin
        if (enqValid[l])
            entries[enqIdx[l]] <= newEntry[l];
    end
    // A stalled lane keeps its outputs
    for (int i = 0; i < LANES; i++) begin
        if (!wbStall[i]) begin
            issueFu[i] <= entries[pickIdx[i]].fu;
            issueOpcode[i] <= entries[pickIdx[i]].opcode;
            issueTagDst[i] <= entries[pickIdx[i]].tagDst;
            issueSqN[i] <= entries[pickIdx[i]].sqN;
        end
    end
end

endmodule

`default_nettype wire

/* verilog/ExecLanes.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module ExecLanes (
    input wire clk,
    input wire rst,

    input wire invalidate,
    input wire [`RS_SQN_W-1:0] invalidateSqN,

    input wire wbStall[`RS_NUM_LANES-1:0],
    input wire issueValid[`RS_NUM_LANES-1:0],
    input wire [`RS_TAG_W-1:0] issueTagDst[`RS_NUM_LANES-1:0],
    input wire [`RS_SQN_W-1:0] issueSqN[`RS_NUM_LANES-1:0],

    output logic resultValid[`RS_RESULT_BUSES-1:0],
    output logic [`RS_TAG_W-1:0] resultTag[`RS_RESULT_BUSES-1:0]
);

for (genvar l = 0; l < `RS_NUM_LANES; l++) begin : gLane
    // Lane 0 handles memory and branches and needs one more stage
    localparam int DEPTH = (l == 0) ? 2 : 1;

    logic stValid[DEPTH];
    logic [`RS_TAG_W-1:0] stTag[DEPTH];
    logic [`RS_SQN_W-1:0] stSqN[DEPTH];

    // An issue slot is taken only while its lane is not stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < DEPTH; s++)
                stValid[s] <= 1'b0;
        end else begin
            stValid[0] <= issueValid[l] && !wbStall[l]
                && !(invalidate && IssuePkg::sqnYounger(issueSqN[l], invalidateSqN));
            for (int s = 1; s < DEPTH; s++)
                stValid[s] <= stValid[s-1]
                    && !(invalidate && IssuePkg::sqnYounger(stSqN[s-1], invalidateSqN));
        end
    end

    always_ff @(posedge clk) begin
        stTag[0] <= issueTagDst[l];
        stSqN[0] <= issueSqN[l];
        for (int s = 1; s < DEPTH; s++) begin
            stTag[s] <= stTag[s-1];
            stSqN[s] <= stSqN[s-1];
        end
    end

    // Younger item leaving the last stage is dropped too
    assign resultValid[l] = stValid[DEPTH-1]
        && !(invalidate && IssuePkg::sqnYounger(stSqN[DEPTH-1], invalidateSqN));
    assign resultTag[l] = stTag[DEPTH-1];
end

endmodule

`default_nettype wire

/* verilog/IssueCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module IssueCore (
    input wire clk,
    input wire rst,

    input wire uopValid[`RS_NUM_LANES-1:0],
    input wire CorePkg::FuType uopFu[`RS_NUM_LANES-1:0],
    input wire CorePkg::OpCode uopOpcode[`RS_NUM_LANES-1:0],
    input wire [`RS_TAG_W-1:0] uopTagA[`RS_NUM_LANES-1:0],
    input wire uopAvailA[`RS_NUM_LANES-1:0],
    input wire [`RS_TAG_W-1:0] uopTagB[`RS_NUM_LANES-1:0],
    input wire uopAvailB[`RS_NUM_LANES-1:0],
    input wire [`RS_TAG_W-1:0] uopTagDst[`RS_NUM_LANES-1:0],
    input wire [`RS_SQN_W-1:0] uopSqN[`RS_NUM_LANES-1:0],
    input wire wbStall[`RS_NUM_LANES-1:0],

    input wire invalidate,
    input wire [`RS_SQN_W-1:0] invalidateSqN,
    input wire maxCommitSqNValid,
    input wire [`RS_SQN_W-1:0] maxCommitSqN,

    output wire issueValid[`RS_NUM_LANES-1:0],
    output wire CorePkg::FuType issueFu[`RS_NUM_LANES-1:0],
    output wire CorePkg::OpCode issueOpcode[`RS_NUM_LANES-1:0],
    output wire [`RS_TAG_W-1:0] issueTagDst[`RS_NUM_LANES-1:0],
    output wire [`RS_SQN_W-1:0] issueSqN[`RS_NUM_LANES-1:0],

    output wire resultValid[`RS_RESULT_BUSES-1:0],
    output wire [`RS_TAG_W-1:0] resultTag[`RS_RESULT_BUSES-1:0],
    output wire [`RS_FREE_W-1:0] freeCount
);

// Station to store queue
wire sqPush[`RS_NUM_LANES-1:0];
wire [`RS_SQN_W-1:0] sqPushSqN[`RS_NUM_LANES-1:0];
wire sqPop;
wire [`RS_SQN_W-1:0] sqHeadSqN;
wire sqEmpty;

ReservationStation station (
    .clk, .rst,
    .uopValid, .uopFu, .uopOpcode,
    .uopTagA, .uopAvailA, .uopTagB, .uopAvailB,
    .uopTagDst, .uopSqN, .wbStall,
    .resultValid, .resultTag,
    .invalidate, .invalidateSqN,
    .maxCommitSqNValid, .maxCommitSqN,
    .sqHeadSqN, .sqEmpty,
    .issueValid, .issueFu, .issueOpcode, .issueTagDst, .issueSqN,
    .sqPush, .sqPushSqN, .sqPop,
    .freeCount
);

StoreOrderQueue storeQueue (
    .clk, .rst,
    .push(sqPush),
    .pushSqN(sqPushSqN),
    .pop(sqPop),
    .invalidate, .invalidateSqN,
    .headSqN(sqHeadSqN),
    .empty(sqEmpty)
);

// Result buses feed back into the station's wakeup
ExecLanes execLanes (
    .clk, .rst,
    .invalidate, .invalidateSqN,
    .wbStall, .issueValid, .issueTagDst, .issueSqN,
    .resultValid, .resultTag
);

endmodule

`default_nettype wire

/* bench/IssueCore_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module IssueCore_asserts (
    input wire clk,
    input wire rst,
    input wire uopValid[`RS_NUM_LANES-1:0],
    input wire wbStall[`RS_NUM_LANES-1:0],
    input wire issueValid[`RS_NUM_LANES-1:0],
    input wire CorePkg::FuType issueFu[`RS_NUM_LANES-1:0],
    input wire CorePkg::OpCode issueOpcode[`RS_NUM_LANES-1:0],
    input wire [`RS_FREE_W-1:0] freeCount
);

// Loads, stores and branches all need lane 0
function automatic logic needsLane0(input CorePkg::FuType fu, input CorePkg::OpCode op);
    if (fu == CorePkg::FU_LSU)
        return op >= CorePkg::OP_LB && op <= CorePkg::OP_SW;
    if (fu == CorePkg::FU_INT)
        return op >= CorePkg::OP_BEQ && op <= CorePkg::OP_JALR;
    return 1'b0;
endfunction

// The station never refuses, so a dispatch must fit in the free slots
freeCountBound: assert property (@(posedge clk) disable iff (rst)
    freeCount <= `RS_QUEUE_SIZE
        && {{(`RS_FREE_W-1){1'b0}}, uopValid[0]} + {{(`RS_FREE_W-1){1'b0}}, uopValid[1]}
            <= freeCount)
    else $error("dispatch exceeds the free count or the station size");

lane1SimpleOnly: assert property (@(posedge clk) disable iff (rst)
    issueValid[1] |-> !needsLane0(issueFu[1], issueOpcode[1]))
    else $error("lane 1 issued a load, store or branch");

lane0StallHold: assert property (@(posedge clk) disable iff (rst)
    (wbStall[0] && !issueValid[0]) |=> !issueValid[0])
    else $error("lane 0 issue valid rose while stalled");

lane1StallHold: assert property (@(posedge clk) disable iff (rst)
    (wbStall[1] && !issueValid[1]) |=> !issueValid[1])
    else $error("lane 1 issue valid rose while stalled");

endmodule

`default_nettype wire

/* bench/IssueCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module IssueCore_tb;

logic clk;
logic rst;
logic uopValid[`RS_NUM_LANES-1:0];
CorePkg::FuType uopFu[`RS_NUM_LANES-1:0];
CorePkg::OpCode uopOpcode[`RS_NUM_LANES-1:0];
logic [`RS_TAG_W-1:0] uopTagA[`RS_NUM_LANES-1:0];
logic uopAvailA[`RS_NUM_LANES-1:0];
logic [`RS_TAG_W-1:0] uopTagB[`RS_NUM_LANES-1:0];
logic uopAvailB[`RS_NUM_LANES-1:0];
logic [`RS_TAG_W-1:0] uopTagDst[`RS_NUM_LANES-1:0];
logic [`RS_SQN_W-1:0] uopSqN[`RS_NUM_LANES-1:0];
logic wbStall[`RS_NUM_LANES-1:0];
logic invalidate;
logic [`RS_SQN_W-1:0] invalidateSqN;
logic maxCommitSqNValid;
logic [`RS_SQN_W-1:0] maxCommitSqN;
wire issueValid[`RS_NUM_LANES-1:0];
wire CorePkg::FuType issueFu[`RS_NUM_LANES-1:0];
wire CorePkg::OpCode issueOpcode[`RS_NUM_LANES-1:0];
wire [`RS_TAG_W-1:0] issueTagDst[`RS_NUM_LANES-1:0];
wire [`RS_SQN_W-1:0] issueSqN[`RS_NUM_LANES-1:0];
wire resultValid[`RS_RESULT_BUSES-1:0];
wire [`RS_TAG_W-1:0] resultTag[`RS_RESULT_BUSES-1:0];
wire [`RS_FREE_W-1:0] freeCount;

// Issue log per sequence number, result log per tag
int cyc;
int issueCnt[64];
int issueCyc[64];
int issueLane[64];
int resultCyc[64];
int errors;
logic [`RS_SQN_W-1:0] s;

// Fields dispatched per sequence number
CorePkg::FuType expFu[64];
CorePkg::OpCode expOp[64];
logic [`RS_TAG_W-1:0] expDst[64];

IssueCore IssueCore_inst (.*);

bind ReservationStation IssueCore_asserts stationAsserts (
    .clk, .rst, .uopValid, .wbStall, .issueValid, .issueFu, .issueOpcode, .freeCount
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

task automatic failNow();
    errors++;
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first error");
endtask

task automatic checkEq(input string name, input int got, input int exp);
    assert (got == exp) else begin
        $display("ERR t=%0t %s expected=%0d got=%0d", $time, name, exp, got);
        failNow();
    end
endtask

task automatic checkTrue(input bit cond, input string what);
    assert (cond) else begin
        $display("At %0t: %s", $time, what);
        failNow();
    end
endtask

// An issue counts once the lane takes it
always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst) begin
        for (int l = 0; l < `RS_NUM_LANES; l++) begin
            if (issueValid[l] && !wbStall[l]) begin
                checkEq("issueFu", issueFu[l], expFu[issueSqN[l]]);
                checkEq("issueOpcode", issueOpcode[l], expOp[issueSqN[l]]);
                checkEq("issueTagDst", issueTagDst[l], expDst[issueSqN[l]]);
                issueCnt[issueSqN[l]]++;
                issueCyc[issueSqN[l]] = cyc;
                issueLane[issueSqN[l]] = l;
            end
        end
        for (int b = 0; b < `RS_RESULT_BUSES; b++)
            if (resultValid[b])
                resultCyc[resultTag[b]] = cyc;
    end
end

task automatic clearLog();
    for (int i = 0; i < 64; i++) begin
        issueCnt[i] = 0;
        issueCyc[i] = -1;
        issueLane[i] = -1;
        resultCyc[i] = -1;
    end
endtask

task automatic setUop(input int lane, input CorePkg::FuType fu, input CorePkg::OpCode op,
                      input logic [`RS_TAG_W-1:0] tagA, input logic availA,
                      input logic [`RS_TAG_W-1:0] dst, input logic [`RS_SQN_W-1:0] sqn);
    uopValid[lane] = 1'b1;
    uopFu[lane] = fu;
    uopOpcode[lane] = op;
    uopTagA[lane] = tagA;
    uopAvailA[lane] = availA;
    uopTagB[lane] = `RS_TAG_W'($urandom);
    uopAvailB[lane] = 1'b1;
    uopTagDst[lane] = dst;
    uopSqN[lane] = sqn;
    expFu[sqn] = fu;
    expOp[sqn] = op;
    expDst[sqn] = dst;
endtask

// Returns the cycle number of the dispatch edge
task automatic pushCycle(output int d);
    @(negedge clk);
    d = cyc;
    for (int l = 0; l < `RS_NUM_LANES; l++)
        uopValid[l] = 1'b0;
endtask

task automatic waitIssued(input logic [`RS_SQN_W-1:0] sqn);
    int n;
    n = 0;
    while (issueCnt[sqn] == 0 && n < 60) begin
        @(negedge clk);
        n++;
    end
    checkTrue(issueCnt[sqn] != 0, $sformatf("micro-op %0d never issued", sqn));
endtask

task automatic waitResult(input logic [`RS_TAG_W-1:0] tag);
    int n;
    n = 0;
    while (resultCyc[tag] < 0 && n < 60) begin
        @(negedge clk);
        n++;
    end
    checkTrue(resultCyc[tag] >= 0, $sformatf("tag %0d never broadcast", tag));
endtask

task automatic waitQuiet();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 4 && n < 100) begin
        @(negedge clk);
        n++;
        if (freeCount == `RS_QUEUE_SIZE && !issueValid[0] && !issueValid[1]
                && !resultValid[0] && !resultValid[1])
            quiet++;
        else
            quiet = 0;
    end
    checkTrue(quiet >= 4, "station did not drain");
endtask

task automatic simpleIssue();
    int d;
    logic [`RS_TAG_W-1:0] dst;
    dst = `RS_TAG_W'($urandom);
    clearLog();
    setUop(0, CorePkg::FU_INT, CorePkg::OP_ADD, `RS_TAG_W'($urandom), 1'b1, dst, s);
    pushCycle(d);
    checkEq("freeCount", freeCount, `RS_QUEUE_SIZE - 1);
    waitIssued(s);
    checkEq("issueCyc", issueCyc[s], d + 2);
    checkEq("issueLane", issueLane[s], 0);
    waitResult(dst);
    checkEq("resultCyc", resultCyc[dst], issueCyc[s] + 2);
    waitQuiet();
    s = s + 1;
endtask

task automatic wakeup();
    int d;
    logic [`RS_TAG_W-1:0] t;
    t = `RS_TAG_W'($urandom);
    clearLog();
    setUop(0, CorePkg::FU_INT, CorePkg::OP_ADD, `RS_TAG_W'($urandom), 1'b1, t, s);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_SUB, t, 1'b0, `RS_TAG_W'($urandom), s + 1);
    pushCycle(d);
    waitIssued(s + 1);
    checkTrue(resultCyc[t] >= 0, "consumer issued before producer broadcast");
    checkEq("consumerIssueCyc", issueCyc[s + 1], resultCyc[t] + 2);
    waitQuiet();
    s = s + 2;
endtask

task automatic oldestFirst();
    int d;
    logic [`RS_TAG_W-1:0] t;
    t = `RS_TAG_W'($urandom);
    clearLog();
    setUop(0, CorePkg::FU_INT, CorePkg::OP_ADD, `RS_TAG_W'($urandom), 1'b1, t, s);
    pushCycle(d);
    // Consumers arrive youngest first and all wake on one broadcast
    setUop(0, CorePkg::FU_INT, CorePkg::OP_ADD, t, 1'b0, `RS_TAG_W'($urandom), s + 4);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_BEQ, t, 1'b0, `RS_TAG_W'($urandom), s + 3);
    pushCycle(d);
    setUop(0, CorePkg::FU_LSU, CorePkg::OP_LW, t, 1'b0, `RS_TAG_W'($urandom), s + 2);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_OR, t, 1'b0, `RS_TAG_W'($urandom), s + 1);
    pushCycle(d);
    for (int i = 1; i <= 4; i++)
        waitIssued(s + i);
    checkEq("lane of oldest", issueLane[s + 1], 0);
    checkEq("lane of younger simple", issueLane[s + 4], 1);
    checkEq("issueCyc younger simple", issueCyc[s + 4], issueCyc[s + 1]);
    checkEq("lane of load", issueLane[s + 2], 0);
    checkEq("lane of branch", issueLane[s + 3], 0);
    checkTrue(issueCyc[s + 1] < issueCyc[s + 2], "load issued before older op");
    checkTrue(issueCyc[s + 2] < issueCyc[s + 3], "branch issued before older load");
    waitQuiet();
    s = s + 5;
endtask

task automatic memoryOrder();
    int d;
    clearLog();
    maxCommitSqNValid = 1'b1;
    maxCommitSqN = s - 1;
    setUop(0, CorePkg::FU_LSU, CorePkg::OP_SW, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s);
    setUop(1, CorePkg::FU_LSU, CorePkg::OP_LW, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s + 1);
    pushCycle(d);
    repeat (12) begin
        @(negedge clk);
        checkEq("store issued past commit limit", issueCnt[s], 0);
        checkEq("load issued before older store", issueCnt[s + 1], 0);
    end
    maxCommitSqN = s;
    waitIssued(s);
    waitIssued(s + 1);
    checkTrue(issueCyc[s] < issueCyc[s + 1], "load did not wait for the store");
    maxCommitSqNValid = 1'b0;
    waitQuiet();
    s = s + 2;
endtask

task automatic flush();
    int d;
    logic [`RS_TAG_W-1:0] w;
    w = `RS_TAG_W'($urandom);
    clearLog();
    setUop(0, CorePkg::FU_INT, CorePkg::OP_ADD, w, 1'b0, `RS_TAG_W'($urandom), s);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_AND, w, 1'b0, `RS_TAG_W'($urandom), s + 1);
    pushCycle(d);
    setUop(0, CorePkg::FU_INT, CorePkg::OP_XOR, w, 1'b0, `RS_TAG_W'($urandom), s + 2);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_SLL, w, 1'b0, `RS_TAG_W'($urandom), s + 3);
    pushCycle(d);
    invalidate = 1'b1;
    invalidateSqN = s + 1;
    @(negedge clk);
    invalidate = 1'b0;
    checkEq("freeCount", freeCount, `RS_QUEUE_SIZE - 2);
    setUop(0, CorePkg::FU_INT, CorePkg::OP_ADD, `RS_TAG_W'($urandom), 1'b1, w, s + 4);
    pushCycle(d);
    waitIssued(s);
    waitIssued(s + 1);
    waitQuiet();
    checkEq("issueCnt older", issueCnt[s], 1);
    checkEq("issueCnt older", issueCnt[s + 1], 1);
    checkEq("issueCnt flushed", issueCnt[s + 2], 0);
    checkEq("issueCnt flushed", issueCnt[s + 3], 0);
    s = s + 5;
endtask

task automatic backPressure();
    int d;
    clearLog();
    wbStall[0] = 1'b1;
    setUop(0, CorePkg::FU_INT, CorePkg::OP_BEQ, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_ADD, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s + 1);
    pushCycle(d);
    setUop(0, CorePkg::FU_INT, CorePkg::OP_JAL, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s + 2);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_SUB, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s + 3);
    pushCycle(d);
    setUop(0, CorePkg::FU_INT, CorePkg::OP_OR, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s + 4);
    setUop(1, CorePkg::FU_INT, CorePkg::OP_SLT, `RS_TAG_W'($urandom), 1'b1,
           `RS_TAG_W'($urandom), s + 5);
    pushCycle(d);
    repeat (10) begin
        @(negedge clk);
        checkEq("issueValid[0]", issueValid[0], 0);
    end
    // Only the two branches are left waiting for lane 0
    checkEq("freeCount", freeCount, `RS_QUEUE_SIZE - 2);
    checkEq("issueCnt branch", issueCnt[s], 0);
    checkEq("issueCnt simple under stall", issueCnt[s + 5], 1);
    wbStall[0] = 1'b0;
    waitIssued(s);
    waitIssued(s + 2);
    waitQuiet();
    for (int i = 0; i < 6; i++)
        checkEq($sformatf("issueCnt[%0d]", s + i), issueCnt[s + i], 1);
    s = s + 6;
endtask

initial begin
    void'($urandom(54018));
    errors = 0;
    cyc = 0;
    s = '0;
    rst = 1'b1;
    invalidate = 1'b0;
    invalidateSqN = '0;
    maxCommitSqNValid = 1'b0;
    maxCommitSqN = '0;
    for (int l = 0; l < `RS_NUM_LANES; l++) begin
        uopValid[l] = 1'b0;
        uopFu[l] = CorePkg::FU_INT;
        uopOpcode[l] = CorePkg::OP_ADD;
        uopTagA[l] = '0;
        uopAvailA[l] = 1'b0;
        uopTagB[l] = '0;
        uopAvailB[l] = 1'b0;
        uopTagDst[l] = '0;
        uopSqN[l] = '0;
        wbStall[l] = 1'b0;
    end
    clearLog();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    checkEq("freeCount after reset", freeCount, `RS_QUEUE_SIZE);
    simpleIssue();
    wakeup();
    oldestFirst();
    memoryOrder();
    flush();
    backPressure();
    if (errors == 0)
        $display("TEST RESULT: PASS");
    else
        $display("TEST RESULT: FAIL");
    $finish;
end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
verilog/CorePkg.sv
verilog/IssuePkg.sv
verilog/StoreOrderQueue.sv
verilog/ReservationStation.sv
verilog/ExecLanes.sv
verilog/IssueCore.sv
bench/IssueCore_asserts.sv
bench/IssueCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module IssueCore_tb \
    -o simIssueCore

./obj_dir/simIssueCore 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
